//--- verilog/core_pkg.sv
// Shared widths, RV32 opcode and class encodings, and stage records; RV32IM only, no compressed.
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // funct7 value that marks the M extension within the OP major opcode.
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // stores and branches produce no register result, so they are CLS_NONE.
    typedef enum logic [2:0] {
        CLS_ALU  = 3'd0,
        CLS_LOAD = 3'd1,
        CLS_MUL  = 3'd2,
        CLS_NONE = 3'd3
    } op_class_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_wr_en;
        logic                  uses_rs2;
    } dec_info_t;

    // a producer whose result is not ready yet.
    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] addr;
    } stage_tag_t;

    // a producer whose result can be forwarded.
    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } stage_fwd_t;

    typedef struct packed {
        stage_fwd_t fwd;
        op_class_e  cls;
    } exe_stage_t;

    typedef struct packed {
        stage_fwd_t fwd;
        logic       hit;
    } cache_stage_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_wr_en;
        op_class_e             cls;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
    } issue_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] data;
    } bypass_sel_t;

endpackage

//--- verilog/instr_decode.sv
// Register fields of RV32IM instructions only; rs1 reads as x0 for LUI, AUIPC and JAL.
`timescale 1ns/100ps

module instr_decode (
    input  logic [31:0]           instr_i,
    output core_pkg::dec_info_t   dec_o,
    output core_pkg::op_class_e   cls_o
);

    import core_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr_i[6:0]);

    always_comb begin
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.rd       = instr_i[11:7];
        dec_o.rd_wr_en = 1'b0;
        dec_o.uses_rs2 = 1'b0;
        cls_o          = CLS_NONE;

        case (opcode)
            OPC_LOAD: begin
                dec_o.rd_wr_en = 1'b1;
                cls_o          = CLS_LOAD;
            end
            OPC_OP: begin
                dec_o.rd_wr_en = 1'b1;
                dec_o.uses_rs2 = 1'b1;
                cls_o          = (instr_i[31:25] == FUNCT7_MULDIV) ? CLS_MUL : CLS_ALU;
            end
            OPC_OP_IMM, OPC_JALR: begin
                dec_o.rd_wr_en = 1'b1;
                cls_o          = CLS_ALU;
            end
            // these formats carry immediate bits where rs1 would sit.
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                dec_o.rs1      = '0;
                dec_o.rd_wr_en = 1'b1;
                cls_o          = CLS_ALU;
            end
            OPC_STORE, OPC_BRANCH: begin
                dec_o.uses_rs2 = 1'b1;
            end
            default: begin
                cls_o = CLS_NONE;
            end
        endcase
    end

endmodule

//--- verilog/reg_file.sv
// Two asynchronous read ports, one write port at the clock edge; x0 is hardwired to zero.
`timescale 1ns/100ps

module reg_file (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  core_pkg::stage_fwd_t             wr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  raddr_a_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  raddr_b_i,
    output logic [core_pkg::XLEN-1:0]        rdata_a_o,
    output logic [core_pkg::XLEN-1:0]        rdata_b_o
);

    import core_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.wr_en && wr_i.addr != '0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    // a write in this cycle is not visible here, the bypass covers it.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- verilog/bypass_ctrl.sv
// Combinational only; assumes stage records hold stable values for the whole cycle.
`timescale 1ns/100ps

module bypass_ctrl (
    input  core_pkg::dec_info_t    dec_i,
    input  logic                   dec_valid_i,
    input  core_pkg::exe_stage_t   exe_i,
    input  core_pkg::stage_tag_t   mult1_i,
    input  core_pkg::stage_tag_t   mult2_i,
    input  core_pkg::stage_tag_t   mult3_i,
    input  core_pkg::stage_tag_t   mult4_i,
    input  core_pkg::stage_fwd_t   mult5_i,
    input  core_pkg::stage_tag_t   tl_i,
    input  core_pkg::cache_stage_t cache_i,
    input  core_pkg::stage_fwd_t   write_i,
    output core_pkg::bypass_sel_t  byp_a_o,
    output core_pkg::bypass_sel_t  byp_b_o,
    output logic                   stall_o
);

    import core_pkg::*;

    typedef struct packed {
        logic        stall;
        bypass_sel_t sel;
    } op_res_t;

    op_res_t res_a;
    op_res_t res_b;
    logic    waw_stall;

    function automatic logic tag_hit(input stage_tag_t s, input logic [REG_ADDR_W-1:0] addr);
        return s.wr_en && (s.addr == addr);
    endfunction

    function automatic logic fwd_hit(input stage_fwd_t s, input logic [REG_ADDR_W-1:0] addr);
        return s.wr_en && (s.addr == addr);
    endfunction

    function automatic op_res_t fwd_from(input logic [XLEN-1:0] data);
        op_res_t res;
        res          = '0;
        res.sel.en   = 1'b1;
        res.sel.data = data;
        return res;
    endfunction

    // the youngest matching stage decides, older stages are not looked at.
    function automatic op_res_t resolve(
        input logic [REG_ADDR_W-1:0] addr,
        input logic                  active
    );
        op_res_t res;
        res = '0;
        if (!active || addr == '0) begin
            res = '0;
        end else if (fwd_hit(exe_i.fwd, addr)) begin
            if (exe_i.cls == CLS_ALU) begin
                res = fwd_from(exe_i.fwd.data);
            end else begin
                res.stall = 1'b1;
            end
        end else if (tag_hit(mult1_i, addr) || tag_hit(mult2_i, addr)) begin
            res.stall = 1'b1;
        end else if (tag_hit(mult3_i, addr) || tag_hit(mult4_i, addr)) begin
            res.stall = 1'b1;
        end else if (fwd_hit(mult5_i, addr)) begin
            res = fwd_from(mult5_i.data);
        end else if (tag_hit(tl_i, addr)) begin
            res.stall = 1'b1;
        end else if (fwd_hit(cache_i.fwd, addr)) begin
            if (cache_i.hit) begin
                res = fwd_from(cache_i.fwd.data);
            end else begin
                res.stall = 1'b1;
            end
        end else if (fwd_hit(write_i, addr)) begin
            res = fwd_from(write_i.data);
        end
        return res;
    endfunction

    always_comb begin
        res_a = resolve(dec_i.rs1, 1'b1);
        res_b = resolve(dec_i.rs2, dec_i.uses_rs2);
    end

    // a short op must not retire before an older long op to the same rd.
    always_comb begin
        waw_stall = 1'b0;
        if (dec_i.rd_wr_en && dec_i.rd != '0) begin
            waw_stall = tag_hit(mult1_i, dec_i.rd) || tag_hit(mult2_i, dec_i.rd)
                     || tag_hit(mult3_i, dec_i.rd) || tag_hit(mult4_i, dec_i.rd)
                     || tag_hit(tl_i, dec_i.rd);
        end
    end

    assign byp_a_o = res_a.sel;
    assign byp_b_o = res_b.sel;
    assign stall_o = dec_valid_i && (res_a.stall || res_b.stall || waw_stall);

endmodule

//--- verilog/issue_reg.sv
// Loads one issue record per clock; stall or no valid instruction loads an all-zero bubble.
`timescale 1ns/100ps

module issue_reg (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  core_pkg::dec_info_t          dec_i,
    input  core_pkg::op_class_e          cls_i,
    input  logic                         dec_valid_i,
    input  logic                         stall_i,
    input  logic [core_pkg::XLEN-1:0]    rdata_a_i,
    input  logic [core_pkg::XLEN-1:0]    rdata_b_i,
    input  core_pkg::bypass_sel_t        byp_a_i,
    input  core_pkg::bypass_sel_t        byp_b_i,
    output core_pkg::issue_t             issue_o
);

    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    issue_t          issue_d;

    assign op_a = byp_a_i.en ? byp_a_i.data : rdata_a_i;
    assign op_b = byp_b_i.en ? byp_b_i.data : rdata_b_i;

    always_comb begin
        issue_d = '0;
        if (dec_valid_i && !stall_i) begin
            issue_d.valid    = 1'b1;
            issue_d.rd       = dec_i.rd;
            issue_d.rd_wr_en = dec_i.rd_wr_en;
            issue_d.cls      = cls_i;
            issue_d.op_a     = op_a;
            issue_d.op_b     = op_b;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o <= '0;
        end else begin
            issue_o <= issue_d;
        end
    end

endmodule

//--- verilog/operand_stage.sv
// Operand-read stage top; upstream must hold instr_i and instr_valid_i while stall_o is high.
`timescale 1ns/100ps

module operand_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    input  core_pkg::exe_stage_t   exe_i,
    input  core_pkg::stage_tag_t   mult1_i,
    input  core_pkg::stage_tag_t   mult2_i,
    input  core_pkg::stage_tag_t   mult3_i,
    input  core_pkg::stage_tag_t   mult4_i,
    input  core_pkg::stage_fwd_t   mult5_i,
    input  core_pkg::stage_tag_t   tl_i,
    input  core_pkg::cache_stage_t cache_i,
    input  core_pkg::stage_fwd_t   write_i,
    output logic                   stall_o,
    output core_pkg::issue_t       issue_o
);

    import core_pkg::*;

    dec_info_t       dec;
    op_class_e       cls;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    bypass_sel_t     byp_a;
    bypass_sel_t     byp_b;

    instr_decode instr_decode_i (
        .instr_i (instr_i),
        .dec_o   (dec),
        .cls_o   (cls)
    );

    reg_file reg_file_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_i      (write_i),
        .raddr_a_i (dec.rs1),
        .raddr_b_i (dec.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    bypass_ctrl bypass_ctrl_i (
        .dec_i       (dec),
        .dec_valid_i (instr_valid_i),
        .exe_i       (exe_i),
        .mult1_i     (mult1_i),
        .mult2_i     (mult2_i),
        .mult3_i     (mult3_i),
        .mult4_i     (mult4_i),
        .mult5_i     (mult5_i),
        .tl_i        (tl_i),
        .cache_i     (cache_i),
        .write_i     (write_i),
        .byp_a_o     (byp_a),
        .byp_b_o     (byp_b),
        .stall_o     (stall_o)
    );

    issue_reg issue_reg_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec),
        .cls_i       (cls),
        .dec_valid_i (instr_valid_i),
        .stall_i     (stall_o),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .byp_a_i     (byp_a),
        .byp_b_i     (byp_b),
        .issue_o     (issue_o)
    );

endmodule

//--- verification/operand_stage_tb.sv
// Drives later stages directly as records; checks stall_o each cycle and issue_o one cycle later.
`timescale 1ns/100ps

module operand_stage_tb;

    import core_pkg::*;

    typedef struct packed {
        logic   stall;
        issue_t issue;
    } expect_t;

    logic         clk_i = 1'b0;
    logic         rst_n_i;
    logic         instr_valid_i;
    logic [31:0]  instr_i;
    exe_stage_t   exe_i;
    stage_tag_t   mult1_i, mult2_i, mult3_i, mult4_i, tl_i;
    stage_fwd_t   mult5_i, write_i;
    cache_stage_t cache_i;
    logic         stall_o;
    issue_t       issue_o;

    logic [31:0]  shadow [0:31];
    logic [31:0]  lfsr = 32'h4d7d;
    expect_t      prev_exp;

    operand_stage operand_stage_i (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h005, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // the nine producers, youngest first; ready means the data may be forwarded.
    function automatic void lookup(input logic [4:0] a, output logic stall, output logic hit,
                                   output logic [31:0] data);
        logic [8:0]  wen;
        logic [4:0]  addr [0:8];
        logic [8:0]  ready;
        logic [31:0] val [0:8];
        stall = 1'b0;
        hit   = 1'b0;
        data  = '0;
        wen   = {exe_i.fwd.wr_en, mult1_i.wr_en, mult2_i.wr_en, mult3_i.wr_en, mult4_i.wr_en,
                 mult5_i.wr_en, tl_i.wr_en, cache_i.fwd.wr_en, write_i.wr_en};
        ready = {exe_i.cls == CLS_ALU, 4'b0000, 1'b1, 1'b0, cache_i.hit, 1'b1};
        addr[0] = exe_i.fwd.addr;
        addr[1] = mult1_i.addr;
        addr[2] = mult2_i.addr;
        addr[3] = mult3_i.addr;
        addr[4] = mult4_i.addr;
        addr[5] = mult5_i.addr;
        addr[6] = tl_i.addr;
        addr[7] = cache_i.fwd.addr;
        addr[8] = write_i.addr;
        val[0] = exe_i.fwd.data;
        val[5] = mult5_i.data;
        val[7] = cache_i.fwd.data;
        val[8] = write_i.data;
        for (int k = 0; k < 9; k++) begin
            if (!hit && wen[8-k] && addr[k] == a) begin
                hit = 1'b1;
                if (ready[8-k]) begin
                    data = val[k];
                end else begin
                    stall = 1'b1;
                end
            end
        end
    endfunction

    function automatic expect_t predict_outputs();
        logic [6:0]  opc;
        logic [4:0]  rd, rs1, rs2;
        logic        wr, u2, st_a, st_b, hit_a, hit_b, waw;
        op_class_e   cls;
        logic [31:0] d_a, d_b;
        expect_t     e;
        opc = instr_i[6:0];
        rd  = instr_i[11:7];
        rs1 = instr_i[19:15];
        rs2 = instr_i[24:20];
        wr  = 1'b0;
        u2  = 1'b0;
        cls = CLS_NONE;
        case (opc)
            7'b0000011: begin
                wr  = 1'b1;
                cls = CLS_LOAD;
            end
            7'b0110011: begin
                wr  = 1'b1;
                u2  = 1'b1;
                cls = (instr_i[31:25] == 7'd1) ? CLS_MUL : CLS_ALU;
            end
            7'b0010011, 7'b1100111: begin
                wr  = 1'b1;
                cls = CLS_ALU;
            end
            7'b0110111, 7'b0010111, 7'b1101111: begin
                rs1 = '0;
                wr  = 1'b1;
                cls = CLS_ALU;
            end
            7'b0100011, 7'b1100011: u2 = 1'b1;
            default: cls = CLS_NONE;
        endcase
        if (!u2) rs2 = '0;
        // x0 never matches a producer and reads zero from the shadow copy.
        st_a  = 1'b0;
        st_b  = 1'b0;
        hit_a = 1'b0;
        hit_b = 1'b0;
        d_a   = '0;
        d_b   = '0;
        if (rs1 != '0) lookup(rs1, st_a, hit_a, d_a);
        if (rs2 != '0) lookup(rs2, st_b, hit_b, d_b);
        if (!hit_a) d_a = shadow[rs1];
        if (!hit_b) d_b = shadow[instr_i[24:20]];
        waw = wr && rd != '0 && ((mult1_i.wr_en && mult1_i.addr == rd)
              || (mult2_i.wr_en && mult2_i.addr == rd) || (mult3_i.wr_en && mult3_i.addr == rd)
              || (mult4_i.wr_en && mult4_i.addr == rd) || (tl_i.wr_en && tl_i.addr == rd));
        e = '0;
        e.stall = instr_valid_i && (st_a || st_b || waw);
        if (instr_valid_i && !e.stall) begin
            e.issue = {1'b1, rd, wr, cls, d_a, d_b};
        end
        return e;
    endfunction

    // outputs are compared at the falling edge, where inputs and registers are settled.
    always @(negedge clk_i) begin
        expect_t e;
        if (rst_n_i) begin
            e = predict_outputs();
            check_eq(128'(issue_o), 128'(prev_exp.issue), "issue_o");
            check_eq(128'(stall_o), 128'(e.stall), "stall_o");
            prev_exp = e;
            if (write_i.wr_en && write_i.addr != '0) shadow[write_i.addr] = write_i.data;
        end
    end

    task automatic clear_stages();
        exe_i   <= '0;
        mult1_i <= '0;
        mult2_i <= '0;
        mult3_i <= '0;
        mult4_i <= '0;
        mult5_i <= '0;
        tl_i    <= '0;
        cache_i <= '0;
        write_i <= '0;
    endtask

    task automatic present(input logic [31:0] instr);
        @(posedge clk_i);
        clear_stages();
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
    endtask

    task automatic random_stages();
        logic [31:0] v;
        logic [31:0] d;
        draw(24, v);
        draw(32, d);
        exe_i   <= '{fwd: '{v[0] & v[1], {2'b00, v[4:2]}, d}, cls: op_class_e'({1'b0, v[6:5]})};
        mult1_i <= '{v[7] & v[8], {2'b00, v[11:9]}};
        mult2_i <= '{v[12] & v[13], {2'b00, v[16:14]}};
        mult3_i <= '{v[17] & v[18], {2'b00, v[21:19]}};
        draw(24, v);
        mult4_i <= '{v[0] & v[1], {2'b00, v[4:2]}};
        draw(32, d);
        mult5_i <= '{v[5] & v[6], {2'b00, v[9:7]}, d};
        tl_i    <= '{v[10] & v[11], {2'b00, v[14:12]}};
        draw(32, d);
        cache_i <= '{fwd: '{v[15] & v[16], {2'b00, v[19:17]}, d}, hit: v[20]};
        draw(5, v);
        draw(32, d);
        write_i <= '{v[0], {2'b00, v[3:1]}, d};
    endtask

    function automatic logic [31:0] random_instr(input logic [31:0] v);
        logic [4:0] rd, rs1, rs2;
        rd  = {2'b00, v[5:3]};
        rs1 = {2'b00, v[8:6]};
        rs2 = {2'b00, v[11:9]};
        case (v[2:0])
            3'd0: return {12'h010, rs1, 3'b010, rd, 7'b0000011};
            3'd1: return i_type(rd, rs1);
            3'd2: return r_type(7'd0, rd, rs1, rs2);
            3'd3: return r_type(7'd1, rd, rs1, rs2);
            3'd4: return {7'd0, rs2, rs1, 3'b010, 5'd4, 7'b0100011};
            3'd5: return {7'd0, rs2, rs1, 3'b000, 5'd8, 7'b1100011};
            3'd6: return {v[31:12], rd, 7'b0110111};
            default: return {v[31:12], rd, 7'b1101111};
        endcase
    endfunction

    initial begin
        logic [31:0] v;
        int          held;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        exe_i         = '0;
        mult1_i       = '0;
        mult2_i       = '0;
        mult3_i       = '0;
        mult4_i       = '0;
        mult5_i       = '0;
        tl_i          = '0;
        cache_i       = '0;
        write_i       = '0;
        prev_exp      = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_eq(128'(issue_o.valid), 128'(0), "valid after reset");

        // fill x1 to x7 through the write stage, then read them back.
        for (int i = 1; i < 8; i++) begin
            @(posedge clk_i);
            clear_stages();
            instr_valid_i <= 1'b0;
            write_i <= '{1'b1, 5'(i), 32'h1000_0000 * i + 32'h11 * i};
        end
        for (int i = 0; i < 8; i++) present(r_type(7'd0, 5'd9, 5'(i), 5'((i + 1) % 8)));

        // exe wins over the older mult5 entry for the same register.
        present(r_type(7'd0, 5'd4, 5'd3, 5'd3));
        exe_i   <= '{'{1'b1, 5'd3, 32'hAAAA_0001}, CLS_ALU};
        mult5_i <= '{1'b1, 5'd3, 32'hBBBB_0002};

        // each stall source alone on rs1.
        for (int k = 0; k < 8; k++) begin
            present(i_type(5'd6, 5'd2));
            case (k)
                0: exe_i <= '{'{1'b1, 5'd2, 32'h1}, CLS_LOAD};
                1: exe_i <= '{'{1'b1, 5'd2, 32'h2}, CLS_MUL};
                2: mult1_i <= '{1'b1, 5'd2};
                3: mult2_i <= '{1'b1, 5'd2};
                4: mult3_i <= '{1'b1, 5'd2};
                5: mult4_i <= '{1'b1, 5'd2};
                6: tl_i <= '{1'b1, 5'd2};
                default: cache_i <= '{'{1'b1, 5'd2, 32'h3}, 1'b0};
            endcase
            @(negedge clk_i);
            check_eq(128'(stall_o), 128'(1), "stall from one stage");
        end

        present(r_type(7'd0, 5'd1, 5'd5, 5'd6));
        mult5_i <= '{1'b1, 5'd5, 32'hC0DE_0005};
        cache_i <= '{'{1'b1, 5'd6, 32'hCAC4_0006}, 1'b1};
        present(r_type(7'd0, 5'd1, 5'd7, 5'd0));
        write_i <= '{1'b1, 5'd7, 32'h7777_0007};

        // write-after-write with no operand match.
        present(i_type(5'd5, 5'd0));
        mult2_i <= '{1'b1, 5'd5};
        present(i_type(5'd5, 5'd0));
        tl_i <= '{1'b1, 5'd5};
        @(negedge clk_i);
        check_eq(128'(stall_o), 128'(1), "write-after-write stall");

        held = 0;
        for (int n = 0; n < 400; n++) begin
            @(posedge clk_i);
            if (instr_valid_i && stall_o) begin
                held++;
                if (held > 60) begin
                    $display("timeout: instruction held by stall for more than 60 cycles");
                    $display("TEST FAIL");
                    $fatal(1);
                end
            end else begin
                held = 0;
                draw(32, v);
                instr_i       <= random_instr(v);
                instr_valid_i <= (v[13:12] != 2'b00);
            end
            random_stages();
        end
        @(posedge clk_i);
        clear_stages();
        instr_valid_i <= 1'b0;
        repeat (2) @(negedge clk_i);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sources.f
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/bypass_ctrl.sv
verilog/issue_reg.sv
verilog/operand_stage.sv
verification/operand_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the operand stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module operand_stage_tb \
    --Mdir obj_dir -o operand_stage_sim

# the log decides the result, so the run's own exit status is kept out of set -e.
./obj_dir/operand_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
